//--- Bender.yml
package:
  name: dma_ahb_master

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/dma_pkg.sv
      - logic/dma_channel_ctrl.sv
      - logic/dma_burst_fsm.sv
      - logic/dma_word_buffer.sv
      - logic/dma_ahb_master.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/ahb_mem_model.sv
      - test/tb_dma_ahb_master.sv

//--- logic/dma_ahb_master.sv
`timescale 1ns/1ps
`default_nettype none

module dma_ahb_master (
    input  logic              m_HCLK,
    input  logic              m_HRESETn,
    input  logic              req,
    input  dma_pkg::dma_cfg_t cfg,
    input  logic              irq_mask,
    input  logic              irq_clr,
    input  logic              HREADY,
    input  logic              HGRANT,
    input  dma_pkg::data_t    HRDATA,
    output logic              ack,
    output logic              irq,
    output logic              irq_status,
    output dma_pkg::htrans_t  HTRANS,
    output dma_pkg::hburst_t  HBURST,
    output dma_pkg::hsize_t   HSIZE,
    output dma_pkg::addr_t    HADDR,
    output logic              HWRITE,
    output dma_pkg::data_t    HWDATA,
    output logic              HBUSREQ
);

    logic                 start;
    dma_pkg::burst_plan_t plan;
    dma_pkg::addr_t       src_addr;
    dma_pkg::addr_t       dst_addr;
    logic                 last_round;
    logic                 src_beat;
    logic                 dst_beat;
    logic                 fill;
    logic                 drain;
    logic                 round_done;
    logic                 xfer_done;
    dma_pkg::ahb_cmd_t    cmd;

    dma_channel_ctrl u_ctrl (
        .m_HCLK     (m_HCLK),
        .m_HRESETn  (m_HRESETn),
        .req        (req),
        .cfg        (cfg),
        .irq_mask   (irq_mask),
        .irq_clr    (irq_clr),
        .src_beat   (src_beat),
        .dst_beat   (dst_beat),
        .round_done (round_done),
        .xfer_done  (xfer_done),
        .ack        (ack),
        .start      (start),
        .plan       (plan),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .last_round (last_round),
        .irq_status (irq_status),
        .irq        (irq)
    );

    dma_burst_fsm u_fsm (
        .m_HCLK     (m_HCLK),
        .m_HRESETn  (m_HRESETn),
        .start      (start),
        .plan       (plan),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .last_round (last_round),
        .hready     (HREADY),
        .hgrant     (HGRANT),
        .cmd        (cmd),
        .src_beat   (src_beat),
        .dst_beat   (dst_beat),
        .fill       (fill),
        .drain      (drain),
        .round_done (round_done),
        .xfer_done  (xfer_done)
    );

    dma_word_buffer u_buf (
        .m_HCLK     (m_HCLK),
        .m_HRESETn  (m_HRESETn),
        .fill       (fill),
        .drain      (drain),
        .round_done (round_done),
        .hrdata     (HRDATA),
        .hwdata     (HWDATA)
    );

    // AHB pins
    assign HTRANS  = cmd.htrans;
    assign HBURST  = cmd.hburst;
    assign HSIZE   = cmd.hsize;
    assign HADDR   = cmd.haddr;
    assign HWRITE  = cmd.hwrite;
    assign HBUSREQ = cmd.hbusreq;

endmodule

`default_nettype wire

//--- logic/dma_burst_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_params.svh"

module dma_burst_fsm (
    input  logic                 m_HCLK,
    input  logic                 m_HRESETn,
    input  logic                 start,
    input  dma_pkg::burst_plan_t plan,
    input  dma_pkg::addr_t       src_addr,
    input  dma_pkg::addr_t       dst_addr,
    input  logic                 last_round,
    input  logic                 hready,
    input  logic                 hgrant,
    output dma_pkg::ahb_cmd_t    cmd,
    output logic                 src_beat,
    output logic                 dst_beat,
    output logic                 fill,
    output logic                 drain,
    output logic                 round_done,
    output logic                 xfer_done
);

    dma_pkg::master_state_e state;
    dma_pkg::master_state_e state_nxt;
    dma_pkg::beat_cnt_t     addr_cnt;     // address beats accepted in this phase
    logic                   addr_last;
    logic                   bus_ok;
    logic                   in_rdata;
    logic                   in_wdata;
    logic                   nonseq_go;
    logic                   seq_go;

    assign addr_last = (addr_cnt == plan.len);
    assign bus_ok    = hgrant && hready;
    assign in_rdata  = (state == dma_pkg::RDATA);
    assign in_wdata  = (state == dma_pkg::WDATA);

    // grant is only checked on the first beat of a burst
    assign nonseq_go = bus_ok && ((state == dma_pkg::READ) || (state == dma_pkg::WRITE) ||
                                  (in_rdata && addr_last));
    assign seq_go    = hready && !addr_last && (in_rdata || in_wdata);

    assign src_beat  = (nonseq_go && (state == dma_pkg::READ)) || (seq_go && in_rdata);
    assign dst_beat  = (nonseq_go && (state != dma_pkg::READ)) || (seq_go && in_wdata);

    // data trails its address by one beat, so a data phase is always open here
    assign fill       = in_rdata && hready;
    assign drain      = in_wdata && hready;
    assign round_done = drain && addr_last;
    assign xfer_done  = round_done && last_round;

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            state    <= dma_pkg::IDLE;
            addr_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (nonseq_go) begin
                addr_cnt <= 5'd1;
            end else if (seq_go) begin
                addr_cnt <= addr_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            dma_pkg::IDLE: begin
                if (start) begin
                    state_nxt = dma_pkg::REQ;
                end
            end
            dma_pkg::REQ: begin
                if (bus_ok) begin
                    state_nxt = dma_pkg::READ;
                end
            end
            dma_pkg::READ: begin
                if (bus_ok) begin
                    state_nxt = dma_pkg::RDATA;
                end
            end
            dma_pkg::RDATA: begin
                if (hready && addr_last) begin
                    state_nxt = hgrant ? dma_pkg::WDATA : dma_pkg::WRITE;
                end
            end
            dma_pkg::WRITE: begin
                if (bus_ok) begin
                    state_nxt = dma_pkg::WDATA;
                end
            end
            dma_pkg::WDATA: begin
                if (round_done) begin
                    state_nxt = last_round ? dma_pkg::IDLE : dma_pkg::READ;
                end
            end
            default: state_nxt = dma_pkg::IDLE;
        endcase
    end

    always_comb begin
        cmd.htrans  = `HTRANS_IDLE;
        cmd.hburst  = plan.hburst;
        cmd.hsize   = `HSIZE_WORD;
        cmd.haddr   = src_addr;
        cmd.hwrite  = 1'b0;
        cmd.hbusreq = 1'b1;
        case (state)
            dma_pkg::IDLE: cmd.hbusreq = start;   // request as we leave idle
            dma_pkg::REQ:  cmd.hbusreq = 1'b1;    // keep asking until granted
            dma_pkg::READ: begin
                if (hgrant) begin
                    cmd.htrans = `HTRANS_NONSEQ;
                end
            end
            dma_pkg::RDATA: begin
                if (!addr_last) begin
                    cmd.htrans = `HTRANS_SEQ;
                end else begin
                    // last read data overlaps the write address
                    cmd.haddr  = dst_addr;
                    cmd.hwrite = 1'b1;
                    if (hgrant) begin
                        cmd.htrans = `HTRANS_NONSEQ;
                    end
                end
            end
            dma_pkg::WRITE: begin
                cmd.haddr  = dst_addr;
                cmd.hwrite = 1'b1;
                if (hgrant) begin
                    cmd.htrans = `HTRANS_NONSEQ;
                end
            end
            dma_pkg::WDATA: begin
                cmd.haddr  = dst_addr;
                cmd.hwrite = 1'b1;
                if (!addr_last) begin
                    cmd.htrans = `HTRANS_SEQ;
                end else begin
                    cmd.hbusreq = !last_round;   // final write address is out
                end
            end
            default: cmd.hbusreq = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/dma_channel_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_params.svh"

module dma_channel_ctrl (
    input  logic                 m_HCLK,
    input  logic                 m_HRESETn,
    input  logic                 req,
    input  dma_pkg::dma_cfg_t    cfg,
    input  logic                 irq_mask,
    input  logic                 irq_clr,
    input  logic                 src_beat,
    input  logic                 dst_beat,
    input  logic                 round_done,
    input  logic                 xfer_done,
    output logic                 ack,
    output logic                 start,
    output dma_pkg::burst_plan_t plan,
    output dma_pkg::addr_t       src_addr,
    output dma_pkg::addr_t       dst_addr,
    output logic                 last_round,
    output logic                 irq_status,
    output logic                 irq
);

    logic                req_q;
    logic                busy;
    logic                capture;
    logic                short_round;
    dma_pkg::word_cnt_t  cfg_words;
    dma_pkg::word_cnt_t  words_left;
    dma_pkg::burst_sel_t bsel;
    dma_pkg::beat_cnt_t  burst_len;
    dma_pkg::hburst_t    burst_code;

    // new request only from a quiet channel
    assign capture   = req && !req_q && !busy && !ack;
    assign cfg_words = cfg.size[`DMA_SIZE_W-1:2];

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            req_q <= 1'b0;
            busy  <= 1'b0;
            start <= 1'b0;
            ack   <= 1'b0;
        end else begin
            req_q <= req;
            start <= capture && (cfg_words != '0);
            if (capture && (cfg_words != '0)) begin
                busy <= 1'b1;
            end else if (xfer_done) begin
                busy <= 1'b0;
            end
            if (!req) begin
                ack <= 1'b0;
            end else if (xfer_done || (capture && (cfg_words == '0))) begin
                ack <= 1'b1;    // empty transfer acks at once
            end
        end
    end

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            words_left <= '0;
            bsel       <= '0;
        end else if (capture) begin
            words_left <= cfg_words;
            bsel       <= cfg.bsel;
        end else if (round_done) begin
            words_left <= words_left - dma_pkg::word_cnt_t'(plan.len);
        end
    end

    // addresses step one word per accepted address beat
    always_ff @(posedge m_HCLK) begin
        if (capture) begin
            src_addr <= cfg.src;
            dst_addr <= cfg.dst;
        end else begin
            if (src_beat) begin
                src_addr <= src_addr + 'd4;
            end
            if (dst_beat) begin
                dst_addr <= dst_addr + 'd4;
            end
        end
    end

    always_comb begin
        case (bsel)
            `BSEL_SINGLE: begin
                burst_len  = 5'd1;
                burst_code = `HBURST_SINGLE;
            end
            `BSEL_INCR4: begin
                burst_len  = 5'd4;
                burst_code = `HBURST_INCR4;
            end
            `BSEL_INCR8: begin
                burst_len  = 5'd8;
                burst_code = `HBURST_INCR8;
            end
            default: begin
                burst_len  = 5'd16;
                burst_code = `HBURST_INCR16;
            end
        endcase
    end

    // remainder shorter than the burst goes out as undefined length INCR
    assign short_round = words_left < dma_pkg::word_cnt_t'(burst_len);
    assign plan.len    = short_round ? dma_pkg::beat_cnt_t'(words_left) : burst_len;
    assign plan.hburst = short_round ? `HBURST_INCR : burst_code;
    assign last_round  = words_left <= dma_pkg::word_cnt_t'(burst_len);

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            irq_status <= 1'b0;
            irq        <= 1'b0;
        end else begin
            if (xfer_done) begin
                irq_status <= 1'b1;
            end else if (irq_clr) begin
                irq_status <= 1'b0;
            end
            irq <= irq_status && irq_mask;
        end
    end

endmodule

`default_nettype wire

//--- logic/dma_params.svh
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// bus and buffer sizes
`define DMA_ADDR_W      32
`define DMA_DATA_W      32
`define DMA_SIZE_W      12      // transfer size in bytes
`define DMA_BUF_DEPTH   16

// HTRANS
`define HTRANS_IDLE     2'b00
`define HTRANS_NONSEQ   2'b10
`define HTRANS_SEQ      2'b11

// HBURST
`define HBURST_SINGLE   3'b000
`define HBURST_INCR     3'b001
`define HBURST_INCR4    3'b011
`define HBURST_INCR8    3'b101
`define HBURST_INCR16   3'b111

`define HSIZE_WORD      3'b010

// burst select, anything else is INCR16
`define BSEL_SINGLE     3'b000
`define BSEL_INCR4      3'b001
`define BSEL_INCR8      3'b010

`endif

//--- logic/dma_pkg.sv
`default_nettype none
`include "dma_params.svh"

package dma_pkg;

    typedef logic [`DMA_ADDR_W-1:0]            addr_t;
    typedef logic [`DMA_DATA_W-1:0]            data_t;
    typedef logic [`DMA_SIZE_W-1:0]            xfer_size_t;
    typedef logic [`DMA_SIZE_W-3:0]            word_cnt_t;   // size in words
    typedef logic [4:0]                        beat_cnt_t;   // up to 16 beats
    typedef logic [$clog2(`DMA_BUF_DEPTH)-1:0] buf_idx_t;
    typedef logic [2:0]                        burst_sel_t;
    typedef logic [1:0]                        htrans_t;
    typedef logic [2:0]                        hburst_t;
    typedef logic [2:0]                        hsize_t;

    typedef struct packed {
        addr_t      src;
        addr_t      dst;
        xfer_size_t size;
        burst_sel_t bsel;
    } dma_cfg_t;

    // one round of the transfer
    typedef struct packed {
        beat_cnt_t len;
        hburst_t   hburst;
    } burst_plan_t;

    typedef struct packed {
        htrans_t htrans;
        hburst_t hburst;
        hsize_t  hsize;
        addr_t   haddr;
        logic    hwrite;
        logic    hbusreq;
    } ahb_cmd_t;

    typedef enum logic [2:0] {IDLE, REQ, READ, RDATA, WRITE, WDATA} master_state_e;

endpackage

`default_nettype wire

//--- logic/dma_word_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_params.svh"

module dma_word_buffer (
    input  logic           m_HCLK,
    input  logic           m_HRESETn,
    input  logic           fill,
    input  logic           drain,
    input  logic           round_done,
    input  dma_pkg::data_t hrdata,
    output dma_pkg::data_t hwdata
);

    dma_pkg::data_t    mem [`DMA_BUF_DEPTH];
    dma_pkg::buf_idx_t fill_idx;
    dma_pkg::buf_idx_t drain_idx;

    always_ff @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            fill_idx  <= '0;
            drain_idx <= '0;
        end else if (round_done) begin
            fill_idx  <= '0;      // next round starts at slot 0
            drain_idx <= '0;
        end else begin
            if (fill) begin
                fill_idx <= fill_idx + 1'b1;
            end
            if (drain) begin
                drain_idx <= drain_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge m_HCLK) begin
        if (fill) begin
            mem[fill_idx] <= hrdata;
        end
    end

    assign hwdata = mem[drain_idx];   // valid through the write data phase

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/dma_pkg.sv
logic/dma_channel_ctrl.sv
logic/dma_burst_fsm.sv
logic/dma_word_buffer.sv
logic/dma_ahb_master.sv
test/ahb_mem_model.sv
test/tb_dma_ahb_master.sv

//--- test/ahb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_params.svh"

module ahb_mem_model (
    input  logic             m_HCLK,
    input  logic             m_HRESETn,
    input  logic             wait_en,     // random wait states and grant delays
    input  dma_pkg::htrans_t HTRANS,
    input  dma_pkg::addr_t   HADDR,
    input  logic             HWRITE,
    input  dma_pkg::data_t   HWDATA,
    input  logic             HBUSREQ,
    output logic             HREADY,
    output logic             HGRANT,
    output dma_pkg::data_t   HRDATA
);

    localparam int WORDS     = 1024;    // 4 KB
    localparam int SRC_WORDS = 256;     // random source region at the bottom

    dma_pkg::data_t mem [WORDS];
    logic [15:0]    lfsr;
    logic           stall;
    logic           dph_act;
    logic           dph_wr;
    logic [9:0]     dph_idx;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        logic [15:0]    s;
        dma_pkg::data_t w;
        s = 16'd52;
        for (int i = 0; i < WORDS; i++) begin
            if (i < SRC_WORDS) begin
                for (int b = 0; b < 32; b++) begin
                    s = lfsr_step(s);
                    w = {w[30:0], s[0]};
                end
            end else begin
                w = 32'hC0DE_0000 ^ (i * 32'h0001_0101);
            end
            mem[i] = w;
        end
    end

    assign HREADY = !stall;
    assign HRDATA = mem[dph_idx];

    // address phase to data phase
    always @(posedge m_HCLK or negedge m_HRESETn) begin
        if (!m_HRESETn) begin
            dph_act <= 1'b0;
            dph_wr  <= 1'b0;
            dph_idx <= '0;
        end else if (HREADY) begin
            dph_act <= (HTRANS != `HTRANS_IDLE);
            dph_wr  <= HWRITE;
            dph_idx <= HADDR[11:2];
        end
    end

    always @(posedge m_HCLK) begin
        if (HREADY && dph_act && dph_wr) begin
            mem[dph_idx] <= HWDATA;
        end
    end

    always @(posedge m_HCLK or negedge m_HRESETn) begin : arbiter
        logic [15:0] s;
        logic        b_wait;
        logic        b_grant;
        if (!m_HRESETn) begin
            lfsr   <= 16'd52;
            stall  <= 1'b0;
            HGRANT <= 1'b0;
        end else begin
            s       = lfsr_step(lfsr);
            b_wait  = s[0];
            s       = lfsr_step(s);
            b_wait  = b_wait & s[0];      // about one cycle in four
            s       = lfsr_step(s);
            b_grant = s[0];
            lfsr   <= s;
            stall  <= wait_en && b_wait;
            if (!HBUSREQ) begin
                HGRANT <= 1'b0;
            end else if (!wait_en) begin
                HGRANT <= 1'b1;
            end else if (HTRANS == `HTRANS_IDLE) begin
                HGRANT <= b_grant;        // re-arbitrate only between bursts
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_dma_ahb_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_params.svh"

module tb_dma_ahb_master;

    localparam int CLK_NS      = 40;
    localparam int TOTAL_WORDS = 68;    // words moved over all tests
    localparam int WATCHDOG_NS = (TOTAL_WORDS * 40 + 400) * CLK_NS;

    typedef struct packed {
        dma_pkg::htrans_t htrans;
        dma_pkg::hburst_t hburst;
        dma_pkg::hsize_t  hsize;
        dma_pkg::addr_t   haddr;
        logic             hwrite;
    } beat_t;

    logic              m_HCLK;
    logic              m_HRESETn;
    logic              req;
    dma_pkg::dma_cfg_t cfg;
    logic              irq_mask;
    logic              irq_clr;
    logic              wait_en;
    logic              ack;
    logic              irq;
    logic              irq_status;
    logic              HREADY;
    logic              HGRANT;
    logic              HWRITE;
    logic              HBUSREQ;
    dma_pkg::htrans_t  HTRANS;
    dma_pkg::hburst_t  HBURST;
    dma_pkg::hsize_t   HSIZE;
    dma_pkg::addr_t    HADDR;
    dma_pkg::data_t    HRDATA;
    dma_pkg::data_t    HWDATA;
    beat_t             beats[$];      // accepted address beats of the current transfer
    int                errors;
    int                tests_run;
    int                tests_failed;
    int                test_errors;

    dma_ahb_master UUT (
        .m_HCLK(m_HCLK), .m_HRESETn(m_HRESETn), .req(req), .cfg(cfg),
        .irq_mask(irq_mask), .irq_clr(irq_clr), .HREADY(HREADY), .HGRANT(HGRANT),
        .HRDATA(HRDATA), .ack(ack), .irq(irq), .irq_status(irq_status),
        .HTRANS(HTRANS), .HBURST(HBURST), .HSIZE(HSIZE), .HADDR(HADDR),
        .HWRITE(HWRITE), .HWDATA(HWDATA), .HBUSREQ(HBUSREQ)
    );

    ahb_mem_model u_mem (
        .m_HCLK(m_HCLK), .m_HRESETn(m_HRESETn), .wait_en(wait_en),
        .HTRANS(HTRANS), .HADDR(HADDR), .HWRITE(HWRITE), .HWDATA(HWDATA),
        .HBUSREQ(HBUSREQ), .HREADY(HREADY), .HGRANT(HGRANT), .HRDATA(HRDATA)
    );

    initial m_HCLK = 1'b0;
    always #(CLK_NS / 2) m_HCLK = ~m_HCLK;

    // sampled mid-cycle and taken on the next rising edge
    always @(negedge m_HCLK) begin
        if (m_HRESETn && HREADY && (HTRANS != `HTRANS_IDLE)) begin
            beats.push_back(beat_t'({HTRANS, HBURST, HSIZE, HADDR, HWRITE}));
        end
    end

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t ns %s got %0h exp %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic start_xfer(input dma_pkg::addr_t src_base, dst_base, input int words,
                              input dma_pkg::burst_sel_t bsel);
        @(posedge m_HCLK);
        beats.delete();
        cfg <= '{src: src_base, dst: dst_base,
                 size: dma_pkg::xfer_size_t'(words * 4), bsel: bsel};
        req <= 1'b1;
    endtask

    task automatic wait_ack(input int words);
        int cycles;
        cycles = 0;
        do begin
            @(negedge m_HCLK);
            cycles++;
        end while (!ack && cycles < words * 40 + 20);
        assert (ack) else begin
            $display("ERROR %0t ns ack did not rise within %0d cycles", $time, cycles);
            errors++;
        end
    endtask

    task automatic release_req();
        @(posedge m_HCLK);
        req <= 1'b0;
        @(posedge m_HCLK);
        @(negedge m_HCLK);
        expect_eq("ack", ack, 0);
    endtask

    task automatic compare_mem(input dma_pkg::addr_t src_base, dst_base, input int words);
        for (int i = 0; i < words; i++) begin
            expect_eq($sformatf("mem[%0h]", dst_base + 4 * i),
                      u_mem.mem[dst_base[11:2] + i], u_mem.mem[src_base[11:2] + i]);
        end
    endtask

    // n is the smaller of L and the words left, a short round goes out as INCR
    task automatic verify_bursts(input dma_pkg::addr_t src_base, dst_base, input int words,
                                 input dma_pkg::burst_sel_t bsel);
        int               len;
        int               n;
        int               idx;
        dma_pkg::hburst_t code;
        beat_t            b;
        len  = (bsel == `BSEL_SINGLE) ? 1 : (bsel == `BSEL_INCR4) ? 4 :
               (bsel == `BSEL_INCR8) ? 8 : 16;
        code = (len == 1) ? `HBURST_SINGLE : (len == 4) ? `HBURST_INCR4 :
               (len == 8) ? `HBURST_INCR8 : `HBURST_INCR16;
        expect_eq("address beats", beats.size(), 2 * words);
        idx = 0;
        for (int rem = words; rem > 0; rem -= n) begin
            n = (rem < len) ? rem : len;
            for (int k = 0; k < 2 * n; k++) begin    // reads, then writes
                if (idx < beats.size()) begin
                    b = beats[idx];
                    expect_eq("HTRANS", b.htrans, (k % n == 0) ? `HTRANS_NONSEQ : `HTRANS_SEQ);
                    expect_eq("HBURST", b.hburst, (n == len) ? code : `HBURST_INCR);
                    expect_eq("HSIZE", b.hsize, `HSIZE_WORD);
                    expect_eq("HADDR", b.haddr, ((k < n) ? src_base : dst_base) + 4 * (k % n));
                    expect_eq("HWRITE", b.hwrite, k >= n);
                end
                idx++;
            end
            src_base += 4 * n;
            dst_base += 4 * n;
        end
    endtask

    function automatic int count_nonseq();
        int    cnt;
        beat_t b;
        cnt = 0;
        for (int i = 0; i < beats.size(); i++) begin
            b = beats[i];
            if (b.htrans == `HTRANS_NONSEQ) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic copy_block(input dma_pkg::addr_t src_base, dst_base, input int words,
                              input dma_pkg::burst_sel_t bsel, input int hold);
        @(posedge m_HCLK);
        irq_clr <= 1'b1;                          // status low before each copy
        @(posedge m_HCLK);
        irq_clr <= 1'b0;
        start_xfer(src_base, dst_base, words, bsel);
        wait_ack(words);
        compare_mem(src_base, dst_base, words);   // already in place when ack shows
        expect_eq("HBUSREQ", HBUSREQ, 0);
        expect_eq("irq_status", irq_status, 1);
        for (int i = 0; i < hold; i++) begin
            @(negedge m_HCLK);
            expect_eq("ack", ack, 1);
        end
        release_req();
        verify_bursts(src_base, dst_base, words, bsel);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (errors == test_errors) ? "ok" : "failed");
        test_errors = errors;
    endtask

    task automatic reset_values();
        @(negedge m_HCLK);
        expect_eq("ack", ack, 0);
        expect_eq("irq", irq, 0);
        expect_eq("irq_status", irq_status, 0);
        expect_eq("HBUSREQ", HBUSREQ, 0);
        expect_eq("HTRANS", HTRANS, `HTRANS_IDLE);
        expect_eq("HWRITE", HWRITE, 0);
        end_test("reset values");
    endtask

    task automatic single_bursts();
        copy_block(32'h000, 32'h400, 4, `BSEL_SINGLE, 0);
        expect_eq("NONSEQ beats", count_nonseq(), 8);
        end_test("single bursts");
    endtask

    task automatic incr4_waits();
        @(posedge m_HCLK);
        wait_en <= 1'b1;
        copy_block(32'h040, 32'h500, 16, `BSEL_INCR4, 0);
        expect_eq("NONSEQ beats", count_nonseq(), 8);
        end_test("incr4 with wait states");
    endtask

    task automatic incr16_remainder();
        copy_block(32'h100, 32'h600, 24, 3'b111, 0);
        expect_eq("NONSEQ beats", count_nonseq(), 4);
        end_test("incr16 and incr remainder");
    endtask

    task automatic handshake();
        copy_block(32'h200, 32'h700, 12, `BSEL_INCR8, 3);
        start_xfer(32'h300, 32'hA00, 0, `BSEL_INCR4);
        wait_ack(1);
        for (int i = 0; i < 4; i++) begin
            expect_eq("HBUSREQ", HBUSREQ, 0);    // empty transfer never asks for the bus
            @(negedge m_HCLK);
        end
        release_req();
        expect_eq("NONSEQ beats", count_nonseq(), 0);
        end_test("req/ack handshake");
    endtask

    task automatic interrupt();
        @(posedge m_HCLK);
        irq_clr <= 1'b1;             // drop status left by earlier tests
        @(posedge m_HCLK);
        irq_clr  <= 1'b0;
        irq_mask <= 1'b1;
        @(negedge m_HCLK);
        expect_eq("irq_status", irq_status, 0);
        copy_block(32'h080, 32'h800, 8, `BSEL_INCR8, 0);
        expect_eq("irq", irq, 1);
        @(posedge m_HCLK);
        irq_clr <= 1'b1;
        @(posedge m_HCLK);
        irq_clr <= 1'b0;
        @(negedge m_HCLK);
        expect_eq("irq_status", irq_status, 0);
        expect_eq("irq", irq, 1);    // one cycle behind status
        @(negedge m_HCLK);
        expect_eq("irq", irq, 0);
        @(posedge m_HCLK);
        irq_mask <= 1'b0;
        copy_block(32'h0C0, 32'h900, 4, `BSEL_INCR4, 0);
        repeat (2) @(negedge m_HCLK);
        expect_eq("irq_status", irq_status, 1);
        expect_eq("irq", irq, 0);
        end_test("interrupt mask and clear");
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        m_HRESETn    = 1'b0;
        req          = 1'b0;
        cfg          = '0;
        irq_mask     = 1'b0;
        irq_clr      = 1'b0;
        wait_en      = 1'b0;
        repeat (4) @(posedge m_HCLK);
        m_HRESETn <= 1'b1;
        reset_values();
        single_bursts();
        incr4_waits();
        incr16_remainder();
        handshake();
        interrupt();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog stopped the run after %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
